/* src.f */
rtl/flag_pkg.sv
rtl/alu_core.sv
rtl/flag_ctrl_decode.sv
rtl/process_status_reg.sv
rtl/flag_unit_top.sv
tb/flag_checker.sv
tb/tb_flag_unit.sv

/* Makefile */
# Verilator build and run for the flag unit testbench

VERILATOR ?= verilator
TOP       ?= tb_flag_unit
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TESTS PASSED

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* tb/tb_flag_unit.sv */
`timescale 1ns/1ps

module tb_flag_unit;

    localparam int N_STEPS  = 27;
    localparam int N_RAND   = 40;
    localparam int RST_CYC  = 5;
    localparam int STEP_TMO = 20;   // cycles allowed per step

    typedef struct packed {
        flag_pkg::flag_op_e op;
        flag_pkg::alu_op_e  alu_op;
        logic [7:0]         a;
        logic [7:0]         b;
        logic [7:0]         data_in;
        logic               so;
        logic               brk;
        logic [7:0]         exp_psr;    // status word after the edge
    } step_t;

    logic               clk;
    logic               nrst;
    flag_pkg::flag_op_e op;
    flag_pkg::alu_op_e  alu_op;
    logic [7:0]         a;
    logic [7:0]         b;
    logic [7:0]         data_in;
    logic               so;
    logic               brk;
    logic [7:0]         result;
    flag_pkg::psr_u     psr;
    logic               exp_valid;
    logic [7:0]         exp_psr;
    int                 pass_cnt;
    int                 fail_cnt;
    step_t              steps [N_STEPS];
    step_t              rs;
    integer             seed;
    logic [31:0]        rnd;
    logic               timed_out;
    int                 n_rst;

    always #10 clk = ~clk;

    flag_unit_top i_flag_unit_top (
        .clk     (clk),
        .nrst    (nrst),
        .op      (op),
        .alu_op  (alu_op),
        .a       (a),
        .b       (b),
        .data_in (data_in),
        .so      (so),
        .brk     (brk),
        .result  (result),
        .psr     (psr)
    );

    flag_checker i_flag_checker (
        .clk       (clk),
        .nrst      (nrst),
        .op        (op),
        .alu_op    (alu_op),
        .a         (a),
        .b         (b),
        .data_in   (data_in),
        .so        (so),
        .brk       (brk),
        .result    (result),
        .psr       (psr),
        .exp_valid (exp_valid),
        .exp_psr   (exp_psr),
        .pass_cnt  (pass_cnt),
        .fail_cnt  (fail_cnt)
    );

    // op, alu op, a, b, data_in, so, brk, psr after the edge
    task automatic load_steps();
        steps[0]  = '{flag_pkg::NOP, flag_pkg::PASS, 8'h00, 8'h00, 8'h00, 1'b0, 1'b1, 8'h30};
        steps[1]  = '{flag_pkg::SEC, flag_pkg::PASS, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 8'h01};
        steps[2]  = '{flag_pkg::SED, flag_pkg::PASS, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 8'h09};
        steps[3]  = '{flag_pkg::SEI, flag_pkg::PASS, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 8'h0d};
        steps[4]  = '{flag_pkg::CLC, flag_pkg::PASS, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 8'h0c};
        steps[5]  = '{flag_pkg::CLD, flag_pkg::PASS, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 8'h04};
        steps[6]  = '{flag_pkg::CLI, flag_pkg::PASS, 8'h00, 8'h00, 8'h00, 1'b1, 1'b0, 8'h40};
        steps[7]  = '{flag_pkg::CLV, flag_pkg::PASS, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 8'h00};
        // add: signed overflow, carry out, carry in
        steps[8]  = '{flag_pkg::ALU, flag_pkg::ADC, 8'h50, 8'h50, 8'h00, 1'b0, 1'b0, 8'hc0};
        steps[9]  = '{flag_pkg::ALU, flag_pkg::ADC, 8'hff, 8'h01, 8'h00, 1'b0, 1'b0, 8'h03};
        steps[10] = '{flag_pkg::ALU, flag_pkg::ADC, 8'h10, 8'h20, 8'h00, 1'b0, 1'b0, 8'h00};
        steps[11] = '{flag_pkg::SEC, flag_pkg::PASS, 8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 8'h01};
        steps[12] = '{flag_pkg::ALU, flag_pkg::SBC, 8'h50, 8'hb0, 8'h00, 1'b0, 1'b0, 8'hc0};
        steps[13] = '{flag_pkg::ALU, flag_pkg::SBC, 8'h05, 8'h03, 8'h00, 1'b0, 1'b0, 8'h01};
        // logic ops keep c and v
        steps[14] = '{flag_pkg::ALU, flag_pkg::AND, 8'hf0, 8'h0f, 8'h00, 1'b0, 1'b0, 8'h03};
        steps[15] = '{flag_pkg::ALU, flag_pkg::ORA, 8'h80, 8'h01, 8'h00, 1'b0, 1'b0, 8'h81};
        steps[16] = '{flag_pkg::ALU, flag_pkg::EOR, 8'hff, 8'hff, 8'h00, 1'b1, 1'b0, 8'h43};
        steps[17] = '{flag_pkg::ALU, flag_pkg::ASL, 8'h81, 8'h00, 8'h00, 1'b0, 1'b0, 8'h41};
        steps[18] = '{flag_pkg::ALU, flag_pkg::LSR, 8'h01, 8'h00, 8'h00, 1'b0, 1'b0, 8'h43};
        steps[19] = '{flag_pkg::ALU, flag_pkg::ROL, 8'h40, 8'h00, 8'h00, 1'b0, 1'b0, 8'hc0};
        steps[20] = '{flag_pkg::ALU, flag_pkg::ROR, 8'h01, 8'h00, 8'h00, 1'b0, 1'b0, 8'h43};
        steps[21] = '{flag_pkg::ALU, flag_pkg::CMP, 8'h10, 8'h20, 8'h00, 1'b0, 1'b0, 8'hc0};
        steps[22] = '{flag_pkg::ALU, flag_pkg::CMP, 8'h20, 8'h10, 8'h00, 1'b0, 1'b0, 8'h41};
        // plp ignores bits 5/4, so pin on top of plp and adc
        steps[23] = '{flag_pkg::PLP, flag_pkg::PASS, 8'h00, 8'h00, 8'hff, 1'b0, 1'b0, 8'hcf};
        steps[24] = '{flag_pkg::PLP, flag_pkg::PASS, 8'h00, 8'h00, 8'h30, 1'b0, 1'b1, 8'h30};
        steps[25] = '{flag_pkg::PLP, flag_pkg::PASS, 8'h00, 8'h00, 8'h00, 1'b1, 1'b0, 8'h40};
        steps[26] = '{flag_pkg::ALU, flag_pkg::ADC, 8'h01, 8'h01, 8'h00, 1'b1, 1'b0, 8'h40};
    endtask

    task automatic drive(input step_t s, input logic chk);
        op        = s.op;
        alu_op    = s.alu_op;
        a         = s.a;
        b         = s.b;
        data_in   = s.data_in;
        so        = s.so;
        brk       = s.brk;
        exp_psr   = s.exp_psr;
        exp_valid = chk;   // random steps rely on the model only
    endtask

    // wait until the checker has reported n tests
    task automatic wait_checked(input int n);
        int cyc;
        cyc = 0;
        while ((pass_cnt + fail_cnt) < n && cyc < STEP_TMO) begin
            @(negedge clk);
            cyc++;
        end
        if ((pass_cnt + fail_cnt) < n) begin
            $display("timeout: test %0d not checked within %0d cycles", n - 1, cyc);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        clk       = 1'b0;
        nrst      = 1'b0;
        op        = flag_pkg::NOP;
        alu_op    = flag_pkg::PASS;
        a         = 8'h00;
        b         = 8'h00;
        data_in   = 8'h00;
        so        = 1'b0;
        brk       = 1'b0;
        exp_valid = 1'b0;
        exp_psr   = 8'h00;
        seed      = 32'h12;
        timed_out = 1'b0;
        load_steps();
        n_rst = 0;
        while (n_rst < RST_CYC) begin
            @(negedge clk);
            n_rst++;
        end
        nrst = 1'b1;   // first step goes out on this same falling edge
        for (int i = 0; i < N_STEPS && !timed_out; i++) begin
            drive(steps[i], 1'b1);
            wait_checked(i + 1);
        end
        for (int i = 0; i < N_RAND && !timed_out; i++) begin
            rnd        = $random(seed);
            rs.op      = flag_pkg::flag_op_e'(4'(rnd[7:0] % 8'd10));
            rs.alu_op  = flag_pkg::alu_op_e'(4'(rnd[15:8] % 8'd11));
            rs.brk     = rnd[16];
            rs.so      = (rnd[19:17] == 3'd0);   // so roughly one in eight
            rnd        = $random(seed);
            rs.a       = rnd[7:0];
            rs.b       = rnd[15:8];
            rs.data_in = rnd[23:16];
            rs.exp_psr = 8'h00;
            drive(rs, 1'b0);
            wait_checked(N_STEPS + i + 1);
        end
        exp_valid = 1'b0;
        $display("passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (!timed_out && fail_cnt == 0 && pass_cnt == N_STEPS + N_RAND) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tb/flag_checker.sv */
`timescale 1ns/1ps

module flag_checker (
    input  logic                clk,
    input  logic                nrst,
    input  flag_pkg::flag_op_e  op,
    input  flag_pkg::alu_op_e   alu_op,
    input  logic [7:0]          a,
    input  logic [7:0]          b,
    input  logic [7:0]          data_in,
    input  logic                so,
    input  logic                brk,
    input  logic [7:0]          result,
    input  flag_pkg::psr_u      psr,
    input  logic                exp_valid,  // table row carries a psr value
    input  logic [7:0]          exp_psr,
    output int                  pass_cnt,
    output int                  fail_cnt
);

    flag_pkg::psr_flags_t m;        // model of the stored flags
    logic [9:0]           ref_alu;  // {c, v, result}
    logic [7:0]           want;
    int                   errs;
    int                   id;

    // reference alu in plain integer math
    function automatic logic [9:0] alu_model(input flag_pkg::alu_op_e f, input logic [7:0] x,
                                             input logic [7:0] y, input logic cin);
        int         ux;
        int         uy;
        int         sx;
        int         sy;
        int         t;
        int         ts;
        logic       c;
        logic       v;
        ux = int'(x);
        uy = int'(y);
        sx = int'($signed(x));
        sy = int'($signed(y));
        ts = 0;
        c  = 1'b0;
        case (f)
            flag_pkg::ADC: begin
                t  = ux + uy + int'(cin);
                ts = sx + sy + int'(cin);
            end
            flag_pkg::SBC: begin
                t  = ux - uy - 1 + int'(cin);   // borrow is not carry
                ts = sx - sy - 1 + int'(cin);
            end
            flag_pkg::CMP:  t = ux - uy;
            flag_pkg::AND:  t = int'(x & y);
            flag_pkg::ORA:  t = int'(x | y);
            flag_pkg::EOR:  t = int'(x ^ y);
            flag_pkg::ASL:  t = ux * 2;
            flag_pkg::ROL:  t = ux * 2 + int'(cin);
            flag_pkg::LSR:  t = ux / 2;
            flag_pkg::ROR:  t = ux / 2 + (cin ? 128 : 0);
            flag_pkg::PASS: t = uy;
            default:        t = 0;
        endcase
        if (f == flag_pkg::ADC)
            c = (t > 255);
        else if (f == flag_pkg::SBC || f == flag_pkg::CMP)
            c = (t >= 0);                     // no borrow
        else if (f == flag_pkg::ASL || f == flag_pkg::ROL)
            c = t[8];
        else if (f == flag_pkg::LSR || f == flag_pkg::ROR)
            c = x[0];
        v = (ts > 127) || (ts < -128);        // out of signed range
        return {c, v, t[7:0]};
    endfunction

    always @(posedge clk) begin
        if (!nrst) begin
            m        = '0;
            pass_cnt = 0;
            fail_cnt = 0;
        end else begin
            errs    = 0;
            id      = pass_cnt + fail_cnt;
            ref_alu = alu_model(alu_op, a, b, m.c);
            // result is combinational, check before the edge takes effect
            if (result !== ref_alu[7:0]) begin
                $display("MISMATCH result: dut=%h exp=%h", result, ref_alu[7:0]);
                errs++;
            end
            case (op)
                flag_pkg::ALU: begin
                    m.n = ref_alu[7];
                    m.z = (ref_alu[7:0] == 8'h00);
                    if (alu_op inside {flag_pkg::ADC, flag_pkg::SBC}) begin
                        m.c = ref_alu[9];
                        m.v = ref_alu[8];
                    end else if (alu_op inside {flag_pkg::ASL, flag_pkg::LSR, flag_pkg::ROL,
                                                flag_pkg::ROR, flag_pkg::CMP}) begin
                        m.c = ref_alu[9];   // v untouched
                    end
                end
                flag_pkg::PLP: begin
                    m.n = data_in[7];
                    m.v = data_in[6];
                    m.d = data_in[3];
                    m.i = data_in[2];
                    m.z = data_in[1];
                    m.c = data_in[0];       // bits 5/4 dropped
                end
                flag_pkg::SEC: m.c = 1'b1;
                flag_pkg::CLC: m.c = 1'b0;
                flag_pkg::SEI: m.i = 1'b1;
                flag_pkg::CLI: m.i = 1'b0;
                flag_pkg::SED: m.d = 1'b1;
                flag_pkg::CLD: m.d = 1'b0;
                flag_pkg::CLV: m.v = 1'b0;
                default: ;
            endcase
            if (so)
                m.v = 1'b1;                 // pin beats any micro-op
            want = {m.n, m.v, brk, brk, m.d, m.i, m.z, m.c};
            #2;                             // register output settled
            if (psr.raw !== want) begin
                $display("MISMATCH psr: dut=%h exp=%h", psr.raw, want);
                errs++;
            end
            if (exp_valid && psr.raw !== exp_psr) begin
                $display("MISMATCH psr (table): dut=%h exp=%h", psr.raw, exp_psr);
                errs++;
            end
            if (errs == 0) begin
                pass_cnt++;
                $display("test %0d %s/%s: ok", id, op.name(), alu_op.name());
            end else begin
                fail_cnt++;
                $display("test %0d %s/%s: failed", id, op.name(), alu_op.name());
            end
        end
    end

endmodule

/* rtl/flag_unit_top.sv */
`timescale 1ns/1ps

module flag_unit_top (
    input  logic                clk,
    input  logic                nrst,
    input  flag_pkg::flag_op_e  op,       // flag micro-op
    input  flag_pkg::alu_op_e   alu_op,
    input  logic [7:0]          a,
    input  logic [7:0]          b,
    input  logic [7:0]          data_in,  // plp byte
    input  logic                so,
    input  logic                brk,
    output logic [7:0]          result,   // combinational alu result
    output flag_pkg::psr_u      psr
);

    flag_pkg::alu_out_t  alu_res;
    flag_pkg::psr_ctrl_t ctrl;
    logic [7:0]          db;
    logic                carry;
    logic                overflow;

    assign result = alu_res.result;

    alu_core i_alu_core (
        .a        (a),
        .b        (b),
        .op       (alu_op),
        .carry_in (psr.f.c),   // rotates and adc/sbc use stored c
        .out      (alu_res)
    );

    flag_ctrl_decode i_flag_ctrl_decode (
        .op       (op),
        .alu_op   (alu_op),
        .alu      (alu_res),
        .data_in  (data_in),
        .ctrl     (ctrl),
        .db       (db),
        .carry    (carry),
        .overflow (overflow)
    );

    process_status_reg i_process_status_reg (
        .clk      (clk),
        .nrst     (nrst),
        .ctrl     (ctrl),
        .db       (db),
        .carry    (carry),
        .overflow (overflow),
        .so       (so),
        .brk      (brk),
        .psr      (psr)
    );

endmodule

/* rtl/process_status_reg.sv */
`timescale 1ns/1ps

module process_status_reg (
    input  logic                 clk,
    input  logic                 nrst,
    input  flag_pkg::psr_ctrl_t  ctrl,
    input  logic [7:0]           db,        // bus byte from decode
    input  logic                 carry,     // alu carry
    input  logic                 overflow,  // alu overflow
    input  logic                 so,        // set-overflow pin
    input  logic                 brk,       // break level, shown on bits 5/4
    output flag_pkg::psr_u       psr
);

    flag_pkg::psr_u       db_u;      // db seen by flag name
    flag_pkg::psr_flags_t flags_q;   // stored flags, b bits unused
    flag_pkg::psr_flags_t flags_nxt;

    assign db_u.raw = db;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            flags_q <= '0;
        end else begin
            flags_q <= flags_nxt;
        end
    end

    // per-bit source select, no enable means hold
    assign flags_nxt.c = (ctrl.db_c & db_u.f.c) | (ctrl.manual_c & ctrl.manual_set) |
                         (ctrl.carry_c & carry) |
                         (~ctrl.db_c & ~ctrl.manual_c & ~ctrl.carry_c & flags_q.c);
    assign flags_nxt.z = (ctrl.db_z & db_u.f.z) | (ctrl.dball_z & ~|db) |
                         (~ctrl.db_z & ~ctrl.dball_z & flags_q.z);
    assign flags_nxt.i = (ctrl.db_i & db_u.f.i) | (ctrl.manual_i & ctrl.manual_set) |
                         (~ctrl.db_i & ~ctrl.manual_i & flags_q.i);
    assign flags_nxt.d = (ctrl.db_d & db_u.f.d) | (ctrl.manual_d & ctrl.manual_set) |
                         (~ctrl.db_d & ~ctrl.manual_d & flags_q.d);
    // so and rcl_v win over everything else
    assign flags_nxt.v = (ctrl.db_v & db_u.f.v) | (ctrl.overflow_v & overflow) |
                         ctrl.rcl_v | so |
                         (~ctrl.db_v & ~ctrl.overflow_v & ~ctrl.rcl_v & flags_q.v);
    assign flags_nxt.n = (ctrl.db_n & db_u.f.n) | (~ctrl.db_n & flags_q.n);
    assign flags_nxt.b_hi = 1'b0;   // break bits never stored
    assign flags_nxt.b_lo = 1'b0;

    // output word, break bits straight from brk
    assign psr.f.n    = flags_q.n;
    assign psr.f.v    = flags_q.v;
    assign psr.f.b_hi = brk;
    assign psr.f.b_lo = brk;
    assign psr.f.d    = flags_q.d;
    assign psr.f.i    = flags_q.i;
    assign psr.f.z    = flags_q.z;
    assign psr.f.c    = flags_q.c;

    // decode must pick one c source
    a_c_src_onehot: assert property (@(posedge clk) disable iff (!nrst)
        $onehot0({ctrl.db_c, ctrl.manual_c, ctrl.carry_c}))
        else $error("process_status_reg: more than one c source enabled");

    // and one z source
    a_z_src_onehot: assert property (@(posedge clk) disable iff (!nrst)
        !(ctrl.db_z && ctrl.dball_z))
        else $error("process_status_reg: db_z and dball_z both enabled");

endmodule

/* rtl/flag_ctrl_decode.sv */
`timescale 1ns/1ps

module flag_ctrl_decode (
    input  flag_pkg::flag_op_e   op,
    input  flag_pkg::alu_op_e    alu_op,
    input  flag_pkg::alu_out_t   alu,
    input  logic [7:0]           data_in,  // plp byte
    output flag_pkg::psr_ctrl_t  ctrl,
    output logic [7:0]           db,       // bus byte to the status reg
    output logic                 carry,
    output logic                 overflow
);

    logic alu_arith;   // adc / sbc, touches c and v
    logic alu_carry;   // ops that write c without v

    assign alu_arith = (alu_op == flag_pkg::ADC) || (alu_op == flag_pkg::SBC);
    assign alu_carry = (alu_op == flag_pkg::ASL) || (alu_op == flag_pkg::LSR) ||
                       (alu_op == flag_pkg::ROL) || (alu_op == flag_pkg::ROR) ||
                       (alu_op == flag_pkg::CMP);

    // alu flags pass straight through, strobes decide use
    assign carry    = alu.carry;
    assign overflow = alu.overflow;

    always_comb begin
        ctrl = '0;   // rcl_v and spare stay zero
        db   = 8'd0;
        case (op)
            flag_pkg::ALU: begin
                db           = alu.result;
                ctrl.db_n    = 1'b1;       // n = result[7]
                ctrl.dball_z = 1'b1;       // z = result == 0
                if (alu_arith) begin
                    ctrl.carry_c    = 1'b1;
                    ctrl.overflow_v = 1'b1;
                end else if (alu_carry) begin
                    ctrl.carry_c = 1'b1;   // v left alone
                end
            end
            flag_pkg::PLP: begin
                db        = data_in;
                ctrl.db_c = 1'b1;
                ctrl.db_z = 1'b1;
                ctrl.db_i = 1'b1;
                ctrl.db_d = 1'b1;
                ctrl.db_v = 1'b1;
                ctrl.db_n = 1'b1;
            end
            flag_pkg::SEC: begin
                ctrl.manual_c   = 1'b1;
                ctrl.manual_set = 1'b1;
            end
            flag_pkg::CLC: ctrl.manual_c = 1'b1;   // manual_set low clears
            flag_pkg::SEI: begin
                ctrl.manual_i   = 1'b1;
                ctrl.manual_set = 1'b1;
            end
            flag_pkg::CLI: ctrl.manual_i = 1'b1;
            flag_pkg::SED: begin
                ctrl.manual_d   = 1'b1;
                ctrl.manual_set = 1'b1;
            end
            flag_pkg::CLD: ctrl.manual_d = 1'b1;
            flag_pkg::CLV: ctrl.db_v = 1'b1;       // v from db[6], db is zero here
            default: ;                             // nop, nothing enabled
        endcase
    end

endmodule

/* rtl/alu_core.sv */
`timescale 1ns/1ps

module alu_core (
    input  logic [7:0]                a,
    input  logic [7:0]                b,
    input  flag_pkg::alu_op_e         op,
    input  logic                      carry_in,  // current c flag
    output flag_pkg::alu_out_t        out
);

    logic       is_sub;      // sbc or cmp
    logic [7:0] add_b;       // b or ~b into the adder
    logic       add_cin;
    logic [8:0] sum;         // 9 bits, msb is carry out
    logic       add_ovf;

    // one shared adder for adc, sbc and cmp
    assign is_sub  = (op == flag_pkg::SBC) || (op == flag_pkg::CMP);
    assign add_b   = is_sub ? ~b : b;
    assign add_cin = (op == flag_pkg::CMP) ? 1'b1 : carry_in; // cmp ignores carry
    assign sum     = {1'b0, a} + {1'b0, add_b} + {8'd0, add_cin};

    // operands agree in sign, result does not
    assign add_ovf = (a[7] == add_b[7]) && (sum[7] != a[7]);

    always_comb begin
        out.result   = 8'd0;
        out.carry    = 1'b0;
        out.overflow = 1'b0;
        case (op)
            flag_pkg::ADC, flag_pkg::SBC: begin
                out.result   = sum[7:0];
                out.carry    = sum[8];
                out.overflow = add_ovf;
            end
            flag_pkg::CMP: begin
                out.result = sum[7:0];   // only feeds n/z
                out.carry  = sum[8];     // set when a >= b
            end
            flag_pkg::AND:  out.result = a & b;
            flag_pkg::ORA:  out.result = a | b;
            flag_pkg::EOR:  out.result = a ^ b;
            flag_pkg::ASL: begin
                out.result = {a[6:0], 1'b0};
                out.carry  = a[7];       // bit shifted out
            end
            flag_pkg::LSR: begin
                out.result = {1'b0, a[7:1]};
                out.carry  = a[0];
            end
            flag_pkg::ROL: begin
                out.result = {a[6:0], carry_in};
                out.carry  = a[7];
            end
            flag_pkg::ROR: begin
                out.result = {carry_in, a[7:1]};
                out.carry  = a[0];
            end
            flag_pkg::PASS: out.result = b;
            default: begin
                // unused encodings give zero
                out.result = 8'd0;
            end
        endcase
    end

endmodule

/* rtl/flag_pkg.sv */
package flag_pkg;

    // alu operation select, 4 bits
    typedef enum logic [3:0] {
        ADC  = 4'd0,  // add with carry
        SBC  = 4'd1,  // subtract, carry = not borrow
        AND  = 4'd2,
        ORA  = 4'd3,
        EOR  = 4'd4,
        ASL  = 4'd5,  // shift left, zero in
        LSR  = 4'd6,  // shift right, zero in
        ROL  = 4'd7,  // rotate left through carry
        ROR  = 4'd8,  // rotate right through carry
        CMP  = 4'd9,  // a - b, no carry in
        PASS = 4'd10  // result = b
    } alu_op_e;

    // one flag micro-op per cycle
    typedef enum logic [3:0] {
        NOP = 4'd0,
        ALU = 4'd1,   // n/z always, c/v per alu op class
        PLP = 4'd2,   // pull flags from data byte
        SEC = 4'd3,
        CLC = 4'd4,
        SEI = 4'd5,
        CLI = 4'd6,
        SED = 4'd7,
        CLD = 4'd8,
        CLV = 4'd9    // goes through db with a zero byte
    } flag_op_e;

    // alu output bundle
    typedef struct packed {
        logic [7:0] result;
        logic       carry;     // carry out, or inverse borrow for sbc/cmp
        logic       overflow;  // signed overflow, add/sub only
    } alu_out_t;

    // status register strobes
    typedef struct packed {
        logic db_c;        // bit from db
        logic db_z;
        logic db_i;
        logic db_d;
        logic db_v;
        logic db_n;
        logic manual_c;    // take manual_set
        logic manual_i;
        logic manual_d;
        logic manual_set;  // value for the manual enables
        logic carry_c;     // c from alu carry
        logic dball_z;     // z from db == 0
        logic overflow_v;  // v from alu overflow
        logic rcl_v;       // reserved, force v high
        logic spare;       // always zero
    } psr_ctrl_t;

    // status word by name, msb first
    typedef struct packed {
        logic n, v, b_hi, b_lo, d, i, z, c;
    } psr_flags_t;

    // same byte seen as raw bus data or as named flags
    typedef union packed {
        logic [7:0] raw;
        psr_flags_t f;
    } psr_u;

endpackage
